/* csr_params.svh */
// Widths, CSR addresses and reset values for the machine-mode CSR block.
// Included by the package, the RTL and the testbench.
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN             64
`define CSR_ADDR_W           12
`define CSR_CAUSE_W          7
`define CSR_MTVEC_ALIGN      7       // Low base bits zero in vectored mode.
`define CSR_MTVEC_BASE_RESET 64'h0000_0000_C000_0000

// CSR addresses.
`define CSR_A_MSTATUS        12'h300
`define CSR_A_MIE            12'h304
`define CSR_A_MTVEC          12'h305
`define CSR_A_MSCRATCH       12'h340
`define CSR_A_MEPC           12'h341
`define CSR_A_MCAUSE         12'h342
`define CSR_A_MTVAL          12'h343
`define CSR_A_MIP            12'h344
`define CSR_A_MCOUNTINH      12'h320
`define CSR_A_MCYCLE         12'hB00
`define CSR_A_MINSTRET       12'hB02
`define CSR_A_CYCLE          12'hC00 // User alias of mcycle.
`define CSR_A_INSTRET        12'hC02 // User alias of minstret.

`endif

/* csr_pkg.sv */
// Shared types and helper functions of the machine-mode CSR block.
// Imported by every RTL module and by the testbench.

`include "csr_params.svh"

package csr_pkg;

    // CSR access operations.
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'd0,
        CSR_OP_SET   = 2'd1,
        CSR_OP_CLEAR = 2'd2
    } csr_op_e;

    typedef struct packed {
        logic                   en;      // One-cycle access strobe.
        logic                   wr;
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_req_t;

    typedef struct packed {
        logic                    cpu;    // Exception from the pipeline.
        logic                    intr;   // Interrupt taken.
        logic [`CSR_CAUSE_W-1:0] cause;
        logic [`CSR_XLEN-1:0]    mtval;
        logic [`CSR_XLEN-1:0]    pc;
    } trap_t;

    typedef struct packed {
        logic ext;
        logic tim;
        logic sw;
    } irq_t;

    typedef struct packed {
        logic                 intr;
        logic [`CSR_XLEN-2:0] code;
    } mcause_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_e;

    typedef struct packed {
        logic       mie;
        logic       mpie;
        priv_mode_e mpp;
    } mstatus_t;

    // Exception codes accepted by mcause.
    typedef enum logic [`CSR_CAUSE_W-1:0] {
        TRAP_IALIGN   = 7'd0,
        TRAP_IACCESS  = 7'd1,
        TRAP_IOPCODE  = 7'd2,
        TRAP_BREAKPT  = 7'd3,
        TRAP_LDALIGN  = 7'd4,
        TRAP_LDACCESS = 7'd5,
        TRAP_STALIGN  = 7'd6,
        TRAP_STACCESS = 7'd7,
        TRAP_ECALLM   = 7'd11
    } trap_code_e;

    // New register value for a write, set or clear access.
    function automatic logic [`CSR_XLEN-1:0] csr_merge(
        input logic [`CSR_XLEN-1:0] old_val,
        input logic [`CSR_XLEN-1:0] data,
        input csr_op_e              op
    );
        logic [`CSR_XLEN-1:0] res;
        case (op)
            CSR_OP_SET:   res = old_val | data;
            CSR_OP_CLEAR: res = old_val & ~data;
            default:      res = data;
        endcase
        return res;
    endfunction

    // Architectural mstatus layout, unimplemented fields read zero.
    function automatic logic [`CSR_XLEN-1:0] mstatus_to_word(input mstatus_t s);
        logic [`CSR_XLEN-1:0] w;
        w        = '0;
        w[3]     = s.mie;
        w[7]     = s.mpie;
        w[12:11] = s.mpp;
        return w;
    endfunction

endpackage

/* priv_mode_fsm.sv */
// Machine/User privilege mode tracking.
// Owns mstatus MIE, MPIE and MPP. Traps and MRET take priority over
// a CSR write to mstatus in the same cycle.

`timescale 1ns/1ps

`include "csr_params.svh"

module priv_mode_fsm (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  csr_pkg::trap_t      trap,
    input  logic                mret,
    input  logic                wr_mstatus,
    input  csr_pkg::csr_req_t   csr_req,
    output csr_pkg::priv_mode_e mode,
    output csr_pkg::mstatus_t   mstatus
);

    import csr_pkg::*;

    logic                 trap_any;
    logic [`CSR_XLEN-1:0] wr_word;      // mstatus after the CSR merge.
    priv_mode_e           mode_next;
    mstatus_t             mstatus_next;

    assign trap_any = trap.cpu || trap.intr;
    assign wr_word  = csr_merge(mstatus_to_word(mstatus), csr_req.data, csr_req.op);

    // Next state.
    // ----------------------------------------
    always_comb begin
        mode_next    = mode;
        mstatus_next = mstatus;
        if (trap_any) begin
            mode_next         = PRIV_M;
            mstatus_next.mie  = 1'b0;
            mstatus_next.mpie = mstatus.mie;
            mstatus_next.mpp  = mode;         // Mode we trapped from.
        end else if (mret) begin
            mode_next         = mstatus.mpp;
            mstatus_next.mie  = mstatus.mpie;
            mstatus_next.mpie = 1'b1;
            mstatus_next.mpp  = PRIV_U;
        end else if (wr_mstatus) begin
            mstatus_next.mie  = wr_word[3];
            mstatus_next.mpie = wr_word[7];
            // Anything other than M stores as U.
            mstatus_next.mpp  = (wr_word[12:11] == 2'b11) ? PRIV_M : PRIV_U;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mode         <= PRIV_M;
            mstatus.mie  <= 1'b0;
            mstatus.mpie <= 1'b0;
            mstatus.mpp  <= PRIV_M;
        end else begin
            mode    <= mode_next;
            mstatus <= mstatus_next;
        end
    end

    // Checks.
    // ----------------------------------------

    // Handler always starts with interrupts masked.
    a_mie_off_after_trap: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        trap_any |=> !mstatus.mie
    );

    a_mode_legal: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        mode inside {PRIV_M, PRIV_U}
    );

endmodule

/* perf_counters.sv */
// Cycle and retired-instruction counters with the mcountinhibit bits.
// A CSR write to a counter wins over its increment in that cycle.

`timescale 1ns/1ps

`include "csr_params.svh"

module perf_counters (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 instret,
    input  logic                 wr_mcycle,
    input  logic                 wr_minstret,
    input  logic                 wr_inhibit,
    input  csr_pkg::csr_req_t    csr_req,
    output logic [`CSR_XLEN-1:0] mcycle,
    output logic [`CSR_XLEN-1:0] minstret,
    output logic [2:0]           inhibit
);

    import csr_pkg::*;

    logic                 inhibit_cy;
    logic                 inhibit_ir;
    logic [`CSR_XLEN-1:0] inhibit_word;

    // Bit 1 (time) is not implemented.
    assign inhibit      = {inhibit_ir, 1'b0, inhibit_cy};
    assign inhibit_word = csr_merge({{(`CSR_XLEN-3){1'b0}}, inhibit},
                                    csr_req.data, csr_req.op);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
        end else if (wr_inhibit) begin
            inhibit_cy <= inhibit_word[0];
            inhibit_ir <= inhibit_word[2];
        end
    end

    // Counters.
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcycle <= '0;
        end else if (wr_mcycle) begin
            mcycle <= csr_merge(mcycle, csr_req.data, csr_req.op);
        end else if (!inhibit_cy) begin
            mcycle <= mcycle + 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            minstret <= '0;
        end else if (wr_minstret) begin
            minstret <= csr_merge(minstret, csr_req.data, csr_req.op);
        end else if (instret && !inhibit_ir) begin
            minstret <= minstret + 1'b1;      // One per retired instruction.
        end
    end

    // Free-running step of exactly one.
    a_mcycle_step: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (!inhibit_cy && !wr_mcycle) |=> (mcycle == $past(mcycle) + 1'b1)
    );

endmodule

/* csr_capture_reg.sv */
// CSR register loaded either by a CSR access or by a trap capture.
// T selects the payload type. Capture has priority over the CSR write.

`timescale 1ns/1ps

`include "csr_params.svh"

module csr_capture_reg #(
    parameter type T = logic [`CSR_XLEN-1:0]
) (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              wr_sel,
    input  csr_pkg::csr_req_t csr_req,
    input  logic              capture,
    input  T                  capture_value,
    output T                  value
);

    import csr_pkg::*;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            value <= '0;
        end else if (capture) begin
            value <= capture_value;           // Trap entry.
        end else if (wr_sel) begin
            value <= T'(csr_merge(value, csr_req.data, csr_req.op));
        end
    end

    // The top must drop CSR writes that collide with a trap.
    a_capture_vs_write: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        !(capture && wr_sel)
    );

endmodule

/* csr_regfile.sv */
// Machine-mode CSR block of a 64-bit RISC-V core.
// Serves single-cycle CSR requests, tracks privilege mode over traps and
// MRET and raises the combined interrupt request.

`timescale 1ns/1ps

`include "csr_params.svh"

module csr_regfile (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  csr_pkg::csr_req_t    csr_req,
    input  csr_pkg::trap_t       trap,
    input  logic                 mret,
    input  logic                 instret,
    input  csr_pkg::irq_t        irq,
    output logic [`CSR_XLEN-1:0] csr_rdata,
    output logic                 csr_error,
    output logic                 mode_user,
    output logic [`CSR_XLEN-1:0] mepc,
    output logic [`CSR_XLEN-1:0] mtvec_base,
    output logic [1:0]           mtvec_mode,
    output logic                 irq_req
);

    import csr_pkg::*;

    priv_mode_e           mode;
    mstatus_t             mstatus;
    irq_t                 mie_q;
    logic [`CSR_XLEN-1:0] mie_merged;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mtvec_merged;
    logic                 mtvec_bad;
    logic [`CSR_XLEN-1:0] mepc_q;
    mcause_t              mcause_q;
    mcause_t              mcause_trap;
    logic [`CSR_XLEN-1:0] mcause_merged;
    logic                 mcause_legal;
    logic [`CSR_XLEN-1:0] mtval_q;
    logic [`CSR_XLEN-1:0] mcycle;
    logic [`CSR_XLEN-1:0] minstret;
    logic [2:0]           inhibit;
    logic                 trap_any;
    logic                 acc_m;
    logic                 req_wr;
    logic                 wr_ok;
    logic                 hit_mstatus;
    logic                 hit_mie;
    logic                 hit_mtvec;
    logic                 hit_mscratch;
    logic                 hit_mepc;
    logic                 hit_mcause;
    logic                 hit_mtval;
    logic                 hit_mip;
    logic                 hit_minh;
    logic                 hit_mcycle;
    logic                 hit_minstret;
    logic                 hit_cycle;
    logic                 hit_instret;
    logic                 hit_any;

    // Interrupt bits at their mie/mip positions.
    function automatic logic [`CSR_XLEN-1:0] irq_word(input irq_t l);
        logic [`CSR_XLEN-1:0] w;
        w     = '0;
        w[11] = l.ext;
        w[7]  = l.tim;
        w[3]  = l.sw;
        return w;
    endfunction

    // Decode.
    // ----------------------------------------
    assign trap_any  = trap.cpu || trap.intr;
    assign mode_user = (mode == PRIV_U);
    assign acc_m     = csr_req.en && (mode == PRIV_M);   // Machine-only CSRs.
    assign req_wr    = csr_req.en && csr_req.wr;
    assign wr_ok     = req_wr && !trap_any && !mret;     // Trap/MRET win.

    assign hit_mstatus  = acc_m && (csr_req.addr == `CSR_A_MSTATUS);
    assign hit_mie      = acc_m && (csr_req.addr == `CSR_A_MIE);
    assign hit_mtvec    = acc_m && (csr_req.addr == `CSR_A_MTVEC);
    assign hit_mscratch = acc_m && (csr_req.addr == `CSR_A_MSCRATCH);
    assign hit_mepc     = acc_m && (csr_req.addr == `CSR_A_MEPC);
    assign hit_mcause   = acc_m && (csr_req.addr == `CSR_A_MCAUSE);
    assign hit_mtval    = acc_m && (csr_req.addr == `CSR_A_MTVAL);
    assign hit_mip      = acc_m && (csr_req.addr == `CSR_A_MIP);
    assign hit_minh     = acc_m && (csr_req.addr == `CSR_A_MCOUNTINH);
    assign hit_mcycle   = acc_m && (csr_req.addr == `CSR_A_MCYCLE);
    assign hit_minstret = acc_m && (csr_req.addr == `CSR_A_MINSTRET);
    assign hit_cycle    = csr_req.en && (csr_req.addr == `CSR_A_CYCLE);
    assign hit_instret  = csr_req.en && (csr_req.addr == `CSR_A_INSTRET);

    assign hit_any = hit_mstatus | hit_mie | hit_mtvec | hit_mscratch | hit_mepc |
                     hit_mcause | hit_mtval | hit_mip | hit_minh | hit_mcycle |
                     hit_minstret | hit_cycle | hit_instret;

    // Local registers.
    // ----------------------------------------
    assign mie_merged = csr_merge(irq_word(mie_q), csr_req.data, csr_req.op);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q <= '0;
        end else if (wr_ok && hit_mie) begin
            mie_q <= '{ext: mie_merged[11], tim: mie_merged[7], sw: mie_merged[3]};
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch_q <= '0;
        end else if (wr_ok && hit_mscratch) begin
            mscratch_q <= csr_merge(mscratch_q, csr_req.data, csr_req.op);
        end
    end

    // Mode 1x is reserved, vectored base must be aligned.
    assign mtvec_merged = csr_merge(mtvec_q, csr_req.data, csr_req.op);
    assign mtvec_bad    = mtvec_merged[1] ||
                          (mtvec_merged[0] && |mtvec_merged[`CSR_MTVEC_ALIGN-1:2]);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec_q <= `CSR_MTVEC_BASE_RESET;  // Direct mode.
        end else if (wr_ok && hit_mtvec && !mtvec_bad) begin
            mtvec_q <= mtvec_merged;
        end
    end

    assign mtvec_base = {mtvec_q[`CSR_XLEN-1:2], 2'b00};
    assign mtvec_mode = mtvec_q[1:0];

    // Unsupported mcause values are dropped silently.
    assign mcause_merged = csr_merge(mcause_q, csr_req.data, csr_req.op);

    always_comb begin
        mcause_legal = 1'b0;
        if (mcause_merged[`CSR_XLEN-1:`CSR_CAUSE_W] == '0) begin
            case (mcause_merged[`CSR_CAUSE_W-1:0])
                TRAP_IALIGN, TRAP_IACCESS, TRAP_IOPCODE, TRAP_BREAKPT,
                TRAP_LDALIGN, TRAP_LDACCESS, TRAP_STALIGN, TRAP_STACCESS,
                TRAP_ECALLM: mcause_legal = 1'b1;
                default:     mcause_legal = 1'b0;
            endcase
        end
    end

    assign mcause_trap = {trap.intr, {(`CSR_XLEN-1-`CSR_CAUSE_W){1'b0}}, trap.cause};

    // Submodules.
    // ----------------------------------------
    priv_mode_fsm priv_mode_fsm_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .trap       (trap),
        .mret       (mret),
        .wr_mstatus (wr_ok && hit_mstatus),
        .csr_req    (csr_req),
        .mode       (mode),
        .mstatus    (mstatus)
    );

    perf_counters perf_counters_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instret     (instret),
        .wr_mcycle   (wr_ok && hit_mcycle),
        .wr_minstret (wr_ok && hit_minstret),
        .wr_inhibit  (wr_ok && hit_minh),
        .csr_req     (csr_req),
        .mcycle      (mcycle),
        .minstret    (minstret),
        .inhibit     (inhibit)
    );

    csr_capture_reg #(.T(logic [`CSR_XLEN-1:0])) mepc_reg (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .wr_sel        (wr_ok && hit_mepc),
        .csr_req       (csr_req),
        .capture       (trap_any),
        .capture_value (trap.pc),
        .value         (mepc_q)
    );

    csr_capture_reg #(.T(mcause_t)) mcause_reg (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .wr_sel        (wr_ok && hit_mcause && mcause_legal),
        .csr_req       (csr_req),
        .capture       (trap_any),
        .capture_value (mcause_trap),
        .value         (mcause_q)
    );

    csr_capture_reg #(.T(logic [`CSR_XLEN-1:0])) mtval_reg (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .wr_sel        (wr_ok && hit_mtval),
        .csr_req       (csr_req),
        .capture       (trap.cpu),                    // Interrupts keep mtval.
        .capture_value (trap.mtval),
        .value         (mtval_q)
    );

    assign mepc = {mepc_q[`CSR_XLEN-1:1], 1'b0};

    // Read data, error and interrupt request.
    // ----------------------------------------
    assign csr_rdata =
        ({`CSR_XLEN{hit_mstatus}}  & mstatus_to_word(mstatus))              |
        ({`CSR_XLEN{hit_mie}}      & irq_word(mie_q))                       |
        ({`CSR_XLEN{hit_mtvec}}    & mtvec_q)                               |
        ({`CSR_XLEN{hit_mscratch}} & mscratch_q)                            |
        ({`CSR_XLEN{hit_mepc}}     & mepc)                                  |
        ({`CSR_XLEN{hit_mcause}}   & mcause_q)                              |
        ({`CSR_XLEN{hit_mtval}}    & mtval_q)                               |
        ({`CSR_XLEN{hit_mip}}      & irq_word(irq))                         |
        ({`CSR_XLEN{hit_minh}}     & {{(`CSR_XLEN-3){1'b0}}, inhibit})      |
        ({`CSR_XLEN{hit_mcycle | hit_cycle}}     & mcycle)                  |
        ({`CSR_XLEN{hit_minstret | hit_instret}} & minstret);

    // Unknown or protected writes, read-only aliases, illegal mtvec.
    assign csr_error = req_wr && (!hit_any || hit_cycle || hit_instret ||
                                  (hit_mtvec && mtvec_bad));

    assign irq_req = mstatus.mie && |(irq & mie_q);

endmodule

/* tb_csr_regfile.sv */
// Directed testbench for the machine-mode CSR block.
// Each behaviour runs as one task; a single result line closes the run.

`timescale 1ns/1ps

`include "csr_params.svh"

module tb_csr_regfile;

    import csr_pkg::*;

    localparam int          TIMEOUT_CYCLES = 3000;
    localparam logic [63:0] MIE_BITS       = 64'h888;   // Bits 11, 7 and 3.
    localparam logic [63:0] MPP_M          = 64'h1800;

    logic                 g_clk = 1'b0;
    logic                 g_resetn;
    csr_req_t             csr_req;
    trap_t                trap;
    logic                 mret;
    logic                 instret;
    irq_t                 irq;
    logic [`CSR_XLEN-1:0] csr_rdata;
    logic                 csr_error;
    logic                 mode_user;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mtvec_base;
    logic [1:0]           mtvec_mode;
    logic                 irq_req;

    int unsigned cycle_cnt = 0;
    int unsigned access_cycle;                          // Stamp of the last access.
    int          err_cnt   = 0;
    int          chk_cnt   = 0;
    logic [31:0] lfsr_state = 32'ha17a;

    // Reference copies of the registers.
    logic [63:0] scratch_m;
    logic [63:0] mie_m;
    logic [63:0] mtvec_m;
    logic [63:0] mepc_m;
    logic [63:0] mcause_m;
    logic [63:0] mtval_m;
    logic [63:0] minstret_m;

    always #5 g_clk = ~g_clk;

    always @(posedge g_clk) cycle_cnt <= cycle_cnt + 1;

    csr_regfile csr_regfile_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .csr_req    (csr_req),
        .trap       (trap),
        .mret       (mret),
        .instret    (instret),
        .irq        (irq),
        .csr_rdata  (csr_rdata),
        .csr_error  (csr_error),
        .mode_user  (mode_user),
        .mepc       (mepc),
        .mtvec_base (mtvec_base),
        .mtvec_mode (mtvec_mode),
        .irq_req    (irq_req)
    );

    // Helpers.
    // ----------------------------------------
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic logic [63:0] rand_word(input int n);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < n; i++) w = {w[62:0], lfsr_step()};
        return w;
    endfunction

    // Write, set, clear by index 0, 1, 2.
    function automatic logic [63:0] model_merge(input logic [63:0] old, input logic [63:0] d,
                                                input int k);
        if (k == 0) return d;
        if (k == 1) return old | d;
        return old & ~d;
    endfunction

    function automatic logic [63:0] irq_bits(input logic [2:0] m);
        logic [63:0] w;
        w     = '0;
        w[11] = m[2];
        w[7]  = m[1];
        w[3]  = m[0];
        return w;
    endfunction

    function automatic logic [6:0] legal_cause(input logic [63:0] r);
        case (r % 9)
            0:       return 7'd0;
            1:       return 7'd1;
            2:       return 7'd2;
            3:       return 7'd3;
            4:       return 7'd4;
            5:       return 7'd5;
            6:       return 7'd6;
            7:       return 7'd7;
            default: return 7'd11;                      // Ecall from M.
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // One-cycle request, sampled mid-cycle.
    task automatic csr_access(input logic wr, input csr_op_e op, input logic [11:0] addr,
                              input logic [63:0] data, output logic [63:0] rdata,
                              output logic err);
        @(posedge g_clk);
        #1;
        csr_req.en   = 1'b1;
        csr_req.wr   = wr;
        csr_req.op   = op;
        csr_req.addr = addr;
        csr_req.data = data;
        #4;
        rdata        = csr_rdata;
        err          = csr_error;
        access_cycle = cycle_cnt;
        @(posedge g_clk);
        #1;
        csr_req = '0;
    endtask

    task automatic csr_modify(input csr_op_e op, input logic [11:0] addr, input logic [63:0] d,
                              input logic exp_err);
        logic [63:0] rd;
        logic        err;
        csr_access(1'b1, op, addr, d, rd, err);
        check_eq($sformatf("csr_error @%h", addr), 64'(err), 64'(exp_err));
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [63:0] d, input logic e);
        csr_modify(CSR_OP_WRITE, addr, d, e);
    endtask

    task automatic csr_set(input logic [11:0] addr, input logic [63:0] d, input logic e);
        csr_modify(CSR_OP_SET, addr, d, e);
    endtask

    task automatic csr_clear(input logic [11:0] addr, input logic [63:0] d, input logic e);
        csr_modify(CSR_OP_CLEAR, addr, d, e);
    endtask

    task automatic read_value(input logic [11:0] addr, output logic [63:0] value);
        logic err;
        csr_access(1'b0, CSR_OP_WRITE, addr, '0, value, err);
    endtask

    task automatic csr_read(input logic [11:0] addr, input logic [63:0] exp);
        logic [63:0] rd;
        logic        err;
        csr_access(1'b0, CSR_OP_WRITE, addr, '0, rd, err);
        check_eq($sformatf("csr_rdata @%h", addr), rd, exp);
        check_eq($sformatf("csr_error @%h", addr), 64'(err), 64'h0);
    endtask

    task automatic modify_by_index(input int k, input logic [11:0] addr, input logic [63:0] d);
        case (k)
            0:       csr_write(addr, d, 1'b0);
            1:       csr_set(addr, d, 1'b0);
            default: csr_clear(addr, d, 1'b0);
        endcase
    endtask

    // Trap strobe, updates the reference copies.
    task automatic pulse_trap(input logic cpu, input logic [6:0] cause, input logic [63:0] tval,
                              input logic [63:0] pc);
        @(posedge g_clk);
        #1;
        trap.cpu   = cpu;
        trap.intr  = !cpu;
        trap.cause = cause;
        trap.mtval = tval;
        trap.pc    = pc;
        @(posedge g_clk);
        #1;
        trap     = '0;
        mepc_m   = pc & ~64'h1;
        mcause_m = {!cpu, 56'h0, cause};
        if (cpu) mtval_m = tval;
    endtask

    task automatic pulse_mret();
        @(posedge g_clk);
        #1;
        mret = 1'b1;
        @(posedge g_clk);
        #1;
        mret = 1'b0;
    endtask

    task automatic pulse_instret(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge g_clk);
            #1;
            instret = 1'b1;
        end
        @(posedge g_clk);
        #1;
        instret    = 1'b0;
        minstret_m = minstret_m + 64'(n);
    endtask

    task automatic drive_irq(input logic [2:0] l);
        @(posedge g_clk);
        #1;
        irq = l;
    endtask

    task automatic check_irq(input logic [2:0] l, input logic exp);
        drive_irq(l);
        #4;
        check_eq("irq_req", 64'(irq_req), 64'(exp));
    endtask

    // Tests.
    // ----------------------------------------
    task automatic test_read_modify();
        logic [63:0] d;
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 3; k++) begin
                d = rand_word(64);
                modify_by_index(k, `CSR_A_MSCRATCH, d);
                scratch_m = model_merge(scratch_m, d, k);
                csr_read(`CSR_A_MSCRATCH, scratch_m);
                d = rand_word(64);
                modify_by_index(k, `CSR_A_MIE, d);
                mie_m = model_merge(mie_m, d, k) & MIE_BITS;
                csr_read(`CSR_A_MIE, mie_m);
            end
        end
    endtask

    task automatic test_mtvec();
        logic [63:0] base;
        base = rand_word(64) & ~64'h7F;
        csr_read(`CSR_A_MTVEC, mtvec_m);
        csr_write(`CSR_A_MTVEC, mtvec_m | 64'h2, 1'b1);      // Reserved mode.
        csr_read(`CSR_A_MTVEC, mtvec_m);
        csr_write(`CSR_A_MTVEC, base | 64'h45, 1'b1);        // Vectored, misaligned.
        csr_read(`CSR_A_MTVEC, mtvec_m);
        csr_write(`CSR_A_MTVEC, base | 64'h1, 1'b0);
        mtvec_m = base | 64'h1;
        csr_read(`CSR_A_MTVEC, mtvec_m);
        check_eq("mtvec_base", mtvec_base, base);
        check_eq("mtvec_mode", 64'(mtvec_mode), 64'h1);
        csr_write(`CSR_A_MTVEC, base | 64'h44, 1'b0);        // Direct needs no alignment.
        mtvec_m = base | 64'h44;
        csr_read(`CSR_A_MTVEC, mtvec_m);
        check_eq("mtvec_base", mtvec_base, base | 64'h44);
        check_eq("mtvec_mode", 64'(mtvec_mode), 64'h0);
    endtask

    task automatic test_trap_return();
        logic [63:0] pc;
        csr_set(`CSR_A_MSTATUS, 64'h8, 1'b0);
        csr_read(`CSR_A_MSTATUS, 64'h1808);
        pc = rand_word(64);
        pulse_trap(1'b1, legal_cause(rand_word(4)), rand_word(64), pc);
        check_eq("mepc", mepc, mepc_m);
        csr_read(`CSR_A_MEPC, mepc_m);
        csr_read(`CSR_A_MCAUSE, mcause_m);
        csr_read(`CSR_A_MTVAL, mtval_m);
        csr_read(`CSR_A_MSTATUS, 64'h1880);                  // MIE off, MPIE on, MPP M.
        csr_clear(`CSR_A_MSTATUS, MPP_M, 1'b0);
        csr_write(`CSR_A_MIE, 64'h8, 1'b0);
        mie_m = 64'h8;
        pulse_mret();
        check_eq("mode_user", 64'(mode_user), 64'h1);
        check_irq(3'b001, 1'b1);                             // MIE restored from MPIE.
        drive_irq(3'b000);
        pc = rand_word(64);
        pulse_trap(1'b0, 7'd7, rand_word(64), pc);
        check_eq("mode_user", 64'(mode_user), 64'h0);
        csr_read(`CSR_A_MCAUSE, mcause_m);
        csr_read(`CSR_A_MTVAL, mtval_m);
        csr_read(`CSR_A_MEPC, mepc_m);
        csr_read(`CSR_A_MSTATUS, 64'h80);
    endtask

    task automatic test_user_protect();
        logic [63:0] v0;
        logic [63:0] v1;
        int unsigned c0;
        csr_clear(`CSR_A_MSTATUS, MPP_M, 1'b0);
        pulse_mret();
        check_eq("mode_user", 64'(mode_user), 64'h1);
        csr_write(`CSR_A_MSCRATCH, rand_word(64), 1'b1);
        csr_read(`CSR_A_MSCRATCH, 64'h0);
        csr_read(`CSR_A_MSTATUS, 64'h0);
        csr_write(`CSR_A_CYCLE, 64'h0, 1'b1);
        pulse_instret(3);
        csr_read(`CSR_A_INSTRET, minstret_m);
        read_value(`CSR_A_CYCLE, v0);
        c0 = access_cycle;
        read_value(`CSR_A_CYCLE, v1);
        check_eq("cycle delta", v1 - v0, 64'(access_cycle - c0));
        pulse_trap(1'b1, 7'd2, rand_word(64), rand_word(64));
        check_eq("mode_user", 64'(mode_user), 64'h0);
        csr_read(`CSR_A_MSCRATCH, scratch_m);                // Blocked write left no trace.
        csr_read(`CSR_A_MSTATUS, 64'h80);
    endtask

    task automatic test_counters();
        logic [63:0] v0;
        logic [63:0] v1;
        logic [63:0] d;
        int unsigned c0;
        read_value(`CSR_A_MCYCLE, v0);
        c0 = access_cycle;
        repeat (7) @(posedge g_clk);
        read_value(`CSR_A_MCYCLE, v1);
        check_eq("mcycle delta", v1 - v0, 64'(access_cycle - c0));
        csr_set(`CSR_A_MCOUNTINH, 64'h1, 1'b0);
        csr_read(`CSR_A_MCOUNTINH, 64'h1);
        read_value(`CSR_A_MCYCLE, v0);
        repeat (5) @(posedge g_clk);
        read_value(`CSR_A_MCYCLE, v1);
        check_eq("mcycle inhibited", v1, v0);
        csr_clear(`CSR_A_MCOUNTINH, 64'h1, 1'b0);
        pulse_instret(5 + int'(rand_word(3)));
        csr_read(`CSR_A_MINSTRET, minstret_m);
        d = rand_word(64);
        csr_write(`CSR_A_MCYCLE, d, 1'b0);
        c0 = access_cycle;
        repeat (4) @(posedge g_clk);
        read_value(`CSR_A_MCYCLE, v1);
        check_eq("mcycle after write", v1, d + 64'(access_cycle - c0 - 1));
    endtask

    task automatic test_irq_and_bad();
        for (int gi = 0; gi < 2; gi++) begin
            csr_write(`CSR_A_MSTATUS, MPP_M | (gi == 1 ? 64'h8 : 64'h0), 1'b0);
            for (int mi = 0; mi < 8; mi++) begin
                csr_write(`CSR_A_MIE, irq_bits(3'(mi)), 1'b0);
                for (int li = 0; li < 8; li++) begin
                    check_irq(3'(li), (gi == 1) && ((li & mi) != 0));
                end
            end
        end
        drive_irq(3'b101);
        csr_read(`CSR_A_MIP, 64'h808);
        drive_irq(3'b000);
        csr_write(12'h7C0, rand_word(64), 1'b1);             // Unknown address.
        csr_read(12'h7C0, 64'h0);
        csr_write(`CSR_A_INSTRET, 64'h1, 1'b1);
        csr_write(`CSR_A_MCAUSE, 64'd9, 1'b0);               // Unsupported code.
        csr_read(`CSR_A_MCAUSE, mcause_m);
        csr_write(`CSR_A_MCAUSE, 64'h8000_0000_0000_0003, 1'b0);
        csr_read(`CSR_A_MCAUSE, mcause_m);
        csr_write(`CSR_A_MCAUSE, 64'd5, 1'b0);
        mcause_m = 64'd5;
        csr_read(`CSR_A_MCAUSE, mcause_m);
    endtask

    // Main sequence.
    // ----------------------------------------
    initial begin
        g_resetn   = 1'b0;
        csr_req    = '0;
        trap       = '0;
        mret       = 1'b0;
        instret    = 1'b0;
        irq        = 3'b111;                            // All lines pending through reset.
        scratch_m  = '0;
        mie_m      = '0;
        mtvec_m    = `CSR_MTVEC_BASE_RESET;
        mepc_m     = '0;
        mcause_m   = '0;
        mtval_m    = '0;
        minstret_m = '0;
        repeat (16) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        check_eq("mode_user", 64'(mode_user), 64'h0);
        check_eq("irq_req", 64'(irq_req), 64'h0);
        check_eq("csr_error", 64'(csr_error), 64'h0);
        csr_read(`CSR_A_MSTATUS, MPP_M);                     // MIE and MPIE clear.
        csr_read(`CSR_A_MIE, 64'h0);
        test_read_modify();
        test_mtvec();
        test_trap_return();
        test_user_protect();
        test_counters();
        test_irq_and_bad();
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Run did not finish within %0d cycles, errors so far: %0d", cycle_cnt, err_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
csr_pkg.sv
priv_mode_fsm.sv
perf_counters.sv
csr_capture_reg.sv
csr_regfile.sv
tb_csr_regfile.sv

/* Makefile */
# Verilator build and run of the CSR block testbench.
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_csr_regfile
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) csr_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
